// File: tb.f
+incdir+common
+incdir+tb
common/mips_pkg.sv
common/id_ex_if.sv
decode/id_stage.sv
src/regfile.sv
src/exec_stage.sv
src/mips_pipe_top.sv
tb/tb_top.sv

// File: run.sh
#!/bin/sh
# Compile and run the pipeline testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --top-module tb_top -f tb.f -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

echo "$out" | grep -q "^all tests passed$"

// File: tb/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

`include "mips_consts.svh"

word_t model_regs [`REG_COUNT];

function automatic void clear_model();
	for (int i = 0; i < `REG_COUNT; i++) begin
		model_regs[i] = '0;
	end
endfunction

function automatic word_t model_read(input reg_addr_t r);
	return (r == `REG_ZERO) ? '0 : model_regs[r];  // r0 is hardwired
endfunction

// expected writeback of one instruction, in program order
function automatic logic ref_exec(input word_t inst, output reg_addr_t addr,
		output word_t data);
	word_t      a;
	word_t      b;
	word_t      zimm;
	word_t      simm;
	logic [4:0] sa;
	logic       wr;
	a    = model_read(inst[`RS_FIELD]);
	b    = model_read(inst[`RT_FIELD]);
	zimm = {16'h0, inst[`IMM_FIELD]};
	simm = {{16{inst[15]}}, inst[`IMM_FIELD]};
	sa   = inst[`SA_FIELD];
	wr   = 1'b1;
	addr = inst[`RD_FIELD];
	data = '0;
	case (inst[`OPC_FIELD])
		`OP_SPECIAL: begin
			case (inst[`FUNCT_FIELD])
				`FN_SLL:  data = b << sa;
				`FN_SRL:  data = b >> sa;
				`FN_SRA:  data = word_t'($signed(b) >>> sa);
				`FN_SLLV: data = b << a[4:0];
				`FN_SRLV: data = b >> a[4:0];
				`FN_SRAV: data = word_t'($signed(b) >>> a[4:0]);
				`FN_ADDU: data = a + b;
				`FN_SUBU: data = a - b;
				`FN_AND:  data = a & b;
				`FN_OR:   data = a | b;
				`FN_XOR:  data = a ^ b;
				`FN_NOR:  data = ~(a | b);
				`FN_SLT:  data = {31'b0, $signed(a) < $signed(b)};
				`FN_SLTU: data = {31'b0, a < b};
				`FN_MOVN: begin
					data = a;
					wr   = (b != '0);
				end
				`FN_MOVZ: begin
					data = a;
					wr   = (b == '0);
				end
				default:  wr = 1'b0;  // sync, unknown funct
			endcase
		end
		`OP_ORI:   data = a | zimm;
		`OP_ANDI:  data = a & zimm;
		`OP_XORI:  data = a ^ zimm;
		`OP_LUI:   data = {inst[`IMM_FIELD], 16'h0};
		`OP_ADDIU: data = a + simm;
		`OP_SLTI:  data = {31'b0, $signed(a) < $signed(simm)};
		`OP_SLTIU: data = {31'b0, a < simm};
		default:   wr = 1'b0;  // pref, undefined
	endcase
	if (inst[`OPC_FIELD] != `OP_SPECIAL) begin
		addr = inst[`RT_FIELD];
	end
	if (wr && addr != `REG_ZERO) begin
		model_regs[addr] = data;
	end
	return wr;
endfunction

`endif

// File: tb/tb_top.sv
`include "mips_consts.svh"

module tb_top import mips_pkg::*; ();

	localparam int PERIOD       = 100;
	localparam int RESET_CYCLES = 10;
	localparam int T2_LEN       = 24;
	localparam int T3_LEN       = 8;
	localparam int T4_LEN       = 12;
	localparam int T5_LEN       = 300;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 200 * (T2_LEN + T3_LEN + T4_LEN + T5_LEN);

	logic      clk_i;
	logic      arst_n_i;
	logic      inst_valid_i;
	word_t     inst_i;
	logic      inst_ready_o;
	logic      wb_valid_o;
	reg_addr_t wb_addr_o;
	word_t     wb_data_o;
	logic      wb_ready_i;

	logic      bp_en;    // random back-pressure
	logic      lat_chk;  // check fixed latency
	int        cyc = 0;
	int        errors = 0;
	int        checks = 0;
	int        tests_run = 0;
	int        tests_bad = 0;
	int        test_err0 = 0;
	reg_addr_t exp_addr_q[$];
	word_t     exp_data_q[$];
	int        exp_cyc_q[$];

	`include "tb_model.svh"

	mips_pipe_top DUT (
		.clk_i        (clk_i),
		.arst_n_i     (arst_n_i),
		.inst_valid_i (inst_valid_i),
		.inst_i       (inst_i),
		.inst_ready_o (inst_ready_o),
		.wb_valid_o   (wb_valid_o),
		.wb_addr_o    (wb_addr_o),
		.wb_data_o    (wb_data_o),
		.wb_ready_i   (wb_ready_i)
	);

	initial begin
		clk_i = 1'b0;
		forever #(PERIOD / 2) clk_i = ~clk_i;
	end

	initial begin
		forever begin
			@(negedge clk_i);
			cyc++;
		end
	end

	initial begin
		wb_ready_i = 1'b1;
		forever begin
			@(negedge clk_i);
			wb_ready_i = bp_en ? ($urandom % 3 != 0) : 1'b1;
		end
	end

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	function automatic word_t r_type(input logic [5:0] fn, input int rs, input int rt,
			input int rd, input int sa);
		return {`OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], sa[4:0], fn};
	endfunction

	function automatic word_t i_type(input logic [5:0] opc, input int rs, input int rt,
			input int imm);
		return {opc, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	// small register range keeps the hazards dense
	function automatic word_t random_inst();
		int rs;
		int rt;
		int rd;
		int sa;
		int imm;
		rs  = $urandom % 8;
		rt  = $urandom % 8;
		rd  = $urandom % 8;
		sa  = $urandom % 32;
		imm = $urandom;
		case ($urandom % 23)
			0:  return r_type(`FN_SLL, 0, rt, rd, sa);
			1:  return r_type(`FN_SRL, 0, rt, rd, sa);
			2:  return r_type(`FN_SRA, 0, rt, rd, sa);
			3:  return r_type(`FN_SLLV, rs, rt, rd, 0);
			4:  return r_type(`FN_SRLV, rs, rt, rd, 0);
			5:  return r_type(`FN_SRAV, rs, rt, rd, 0);
			6:  return r_type(`FN_ADDU, rs, rt, rd, 0);
			7:  return r_type(`FN_SUBU, rs, rt, rd, 0);
			8:  return r_type(`FN_AND, rs, rt, rd, 0);
			9:  return r_type(`FN_OR, rs, rt, rd, 0);
			10: return r_type(`FN_XOR, rs, rt, rd, 0);
			11: return r_type(`FN_NOR, rs, rt, rd, 0);
			12: return r_type(`FN_SLT, rs, rt, rd, 0);
			13: return r_type(`FN_SLTU, rs, rt, rd, 0);
			14: return r_type(`FN_MOVN, rs, rt, rd, 0);
			15: return r_type(`FN_MOVZ, rs, rt, rd, 0);
			16: return i_type(`OP_ORI, rs, rt, imm);
			17: return i_type(`OP_ANDI, rs, rt, imm);
			18: return i_type(`OP_XORI, rs, rt, imm);
			19: return i_type(`OP_LUI, 0, rt, imm);
			20: return i_type(`OP_ADDIU, rs, rt, imm);
			21: return i_type(`OP_SLTI, rs, rt, imm);
			default: return i_type(`OP_SLTIU, rs, rt, imm);
		endcase
	endfunction

	// called on a falling edge, returns on the falling edge after acceptance
	task automatic issue(input word_t inst);
		reg_addr_t addr;
		word_t     data;
		inst_valid_i = 1'b1;
		inst_i       = inst;
		@(posedge clk_i);
		while (!inst_ready_o) begin
			@(posedge clk_i);
		end
		if (ref_exec(inst, addr, data)) begin
			exp_addr_q.push_back(addr);
			exp_data_q.push_back(data);
			exp_cyc_q.push_back(cyc);
		end
		@(negedge clk_i);
	endtask

	task automatic end_test(input int num, input string name);
		inst_valid_i = 1'b0;
		while (exp_addr_q.size() != 0) begin
			@(posedge clk_i);
		end
		repeat (3) @(posedge clk_i);  // let non-writing tail leave the pipe
		@(negedge clk_i);
		tests_run++;
		if (errors == test_err0) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			tests_bad++;
			$display("test %0d %s: %0d errors", num, name, errors - test_err0);
		end
		test_err0 = errors;
	endtask

	// compares every writeback transfer against the queue
	initial begin : compare
		reg_addr_t a;
		word_t     d;
		int        c;
		forever begin
			@(posedge clk_i);
			if (arst_n_i && wb_valid_o && !wb_ready_i) begin
				check("inst_ready_o while writeback held", 32'(inst_ready_o), 32'd0);
			end
			if (arst_n_i && wb_valid_o && wb_ready_i) begin
				if (exp_addr_q.size() == 0) begin
					errors++;
					$display("unexpected writeback to register %0d at time %0t",
						wb_addr_o, $time);
				end else begin
					a = exp_addr_q.pop_front();
					d = exp_data_q.pop_front();
					c = exp_cyc_q.pop_front();
					check("wb_addr_o", 32'(wb_addr_o), 32'(a));
					check("wb_data_o", wb_data_o, d);
					if (lat_chk) begin
						check("edges from accept to transfer", 32'(cyc - c), 32'd3);
					end
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * PERIOD);
		$display("watchdog expired with %0d writebacks still missing", exp_addr_q.size());
		$display("tests failed");
		$finish;
	end

	initial begin
		void'($urandom(32'h9c70c5bf));
		arst_n_i     = 1'b0;
		inst_valid_i = 1'b0;
		inst_i       = '0;
		bp_en        = 1'b0;
		lat_chk      = 1'b0;
		clear_model();
		repeat (RESET_CYCLES) @(negedge clk_i);
		arst_n_i = 1'b1;

		@(posedge clk_i);
		check("wb_valid_o after reset", 32'(wb_valid_o), 32'd0);
		check("inst_ready_o after reset", 32'(inst_ready_o), 32'd1);
		end_test(1, "reset state");

		lat_chk = 1'b1;
		issue(i_type(`OP_ORI, 0, 1, 'h00f0));
		issue(i_type(`OP_LUI, 0, 2, 'h8765));
		issue(i_type(`OP_ORI, 2, 2, 'h4321));
		issue(i_type(`OP_ANDI, 2, 3, 'h0ff0));
		issue(i_type(`OP_XORI, 1, 4, 'hffff));
		issue(i_type(`OP_ADDIU, 0, 5, -3));
		issue(i_type(`OP_SLTI, 5, 6, -2));
		issue(i_type(`OP_SLTIU, 5, 7, 5));
		issue(r_type(`FN_ADDU, 1, 2, 8, 0));
		issue(r_type(`FN_SUBU, 1, 2, 9, 0));
		issue(r_type(`FN_AND, 2, 4, 10, 0));
		issue(r_type(`FN_OR, 1, 3, 11, 0));
		issue(r_type(`FN_XOR, 2, 4, 12, 0));
		issue(r_type(`FN_NOR, 1, 3, 13, 0));
		issue(r_type(`FN_SLT, 2, 1, 14, 0));
		issue(r_type(`FN_SLTU, 2, 1, 15, 0));
		issue(r_type(`FN_SLL, 0, 2, 16, 4));
		issue(r_type(`FN_SRL, 0, 2, 17, 8));
		issue(r_type(`FN_SRA, 0, 2, 18, 8));
		issue(r_type(`FN_SLLV, 5, 2, 19, 0));
		issue(r_type(`FN_SRLV, 1, 2, 20, 0));
		issue(r_type(`FN_SRAV, 6, 2, 21, 0));
		issue(r_type(`FN_MOVN, 2, 1, 22, 0));
		issue(r_type(`FN_MOVZ, 1, 0, 23, 0));
		end_test(2, "each operation");
		lat_chk = 1'b0;

		issue(i_type(`OP_ADDIU, 0, 1, 7));
		issue(r_type(`FN_ADDU, 1, 1, 2, 0));
		issue(r_type(`FN_ADDU, 2, 1, 3, 0));  // ex and wb forwards
		issue(r_type(`FN_SUBU, 3, 2, 4, 0));
		issue(r_type(`FN_SLL, 0, 4, 5, 3));
		issue(r_type(`FN_XOR, 5, 4, 6, 0));
		issue(r_type(`FN_OR, 6, 3, 7, 0));
		issue(r_type(`FN_SLTU, 7, 6, 8, 0));
		end_test(3, "dependent chain");

		issue(r_type(`FN_MOVN, 1, 0, 9, 0));
		issue(r_type(`FN_MOVZ, 1, 0, 10, 0));
		issue(r_type(`FN_MOVN, 2, 1, 11, 0));
		issue(r_type(`FN_MOVZ, 2, 1, 12, 0));
		issue(i_type(`OP_ADDIU, 0, 0, 'h55));
		issue(r_type(`FN_OR, 0, 0, 13, 0));
		issue(r_type(`FN_ADDU, 0, 1, 14, 0));
		issue(r_type(`FN_SYNC, 0, 0, 0, 0));
		issue(i_type(`OP_PREF, 1, 3, 0));
		issue(32'hfc000000);
		issue(r_type(6'b111111, 1, 2, 3, 0));
		issue(r_type(`FN_MOVZ, 2, 0, 15, 0));
		end_test(4, "moves, r0 and no-ops");

		bp_en = 1'b1;
		for (int i = 0; i < T5_LEN; i++) begin
			if ($urandom % 4 == 0) begin
				inst_valid_i = 1'b0;
				inst_i       = $urandom;  // junk while idle
				repeat (1 + $urandom % 3) @(negedge clk_i);
			end
			issue(random_inst());
		end
		bp_en = 1'b0;
		end_test(5, "random stream");

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_bad, checks, errors);
		if (errors == 0 && tests_bad == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: src/mips_pipe_top.sv
module mips_pipe_top import mips_pkg::*; (
	input  logic      clk_i,
	input  logic      arst_n_i,
	input  logic      inst_valid_i,
	input  word_t     inst_i,
	output logic      inst_ready_o,
	output logic      wb_valid_o,
	output reg_addr_t wb_addr_o,
	output word_t     wb_data_o,
	input  logic      wb_ready_i
);

	reg_addr_t rd_addr_a;
	reg_addr_t rd_addr_b;
	word_t     rd_data_a;
	word_t     rd_data_b;
	logic      advance;
	logic      ex_fwd_en;
	reg_addr_t ex_fwd_addr;
	word_t     ex_fwd_data;
	logic      wb_fwd_en;
	logic      rf_wr_en;

	id_ex_if id_ex ();

	assign wb_fwd_en = wb_valid_o & (wb_addr_o != '0);  // r0 never forwarded
	assign rf_wr_en  = wb_valid_o & wb_ready_i;        // write on writeback transfer

	id_stage u_id_stage (
		.clk_i         (clk_i),
		.arst_n_i      (arst_n_i),
		.inst_valid_i  (inst_valid_i),
		.inst_i        (inst_i),
		.advance_i     (advance),
		.inst_ready_o  (inst_ready_o),
		.rd_addr_a_o   (rd_addr_a),
		.rd_addr_b_o   (rd_addr_b),
		.rd_data_a_i   (rd_data_a),
		.rd_data_b_i   (rd_data_b),
		.ex_fwd_en_i   (ex_fwd_en),
		.ex_fwd_addr_i (ex_fwd_addr),
		.ex_fwd_data_i (ex_fwd_data),
		.wb_fwd_en_i   (wb_fwd_en),
		.wb_fwd_addr_i (wb_addr_o),
		.wb_fwd_data_i (wb_data_o),
		.id_ex         (id_ex.dec)
	);

	exec_stage u_exec_stage (
		.clk_i         (clk_i),
		.arst_n_i      (arst_n_i),
		.id_ex         (id_ex.exe),
		.wb_ready_i    (wb_ready_i),
		.advance_o     (advance),
		.ex_fwd_en_o   (ex_fwd_en),
		.ex_fwd_addr_o (ex_fwd_addr),
		.ex_fwd_data_o (ex_fwd_data),
		.wb_valid_o    (wb_valid_o),
		.wb_addr_o     (wb_addr_o),
		.wb_data_o     (wb_data_o)
	);

	regfile u_regfile (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.rd_addr_a_i (rd_addr_a),
		.rd_addr_b_i (rd_addr_b),
		.rd_data_a_o (rd_data_a),
		.rd_data_b_o (rd_data_b),
		.wr_en_i     (rf_wr_en),
		.wr_addr_i   (wb_addr_o),
		.wr_data_i   (wb_data_o)
	);

endmodule

// File: src/exec_stage.sv
`include "mips_consts.svh"

module exec_stage import mips_pkg::*; (
	input  logic      clk_i,
	input  logic      arst_n_i,
	id_ex_if.exe      id_ex,
	input  logic      wb_ready_i,
	output logic      advance_o,
	output logic      ex_fwd_en_o,
	output reg_addr_t ex_fwd_addr_o,
	output word_t     ex_fwd_data_o,
	output logic      wb_valid_o,
	output reg_addr_t wb_addr_o,
	output word_t     wb_data_o
);

	word_t      result;
	logic [4:0] shamt;
	logic       cond_ok;
	logic       wr_final;

	assign shamt = id_ex.src_a[4:0];

	always_comb begin
		case (id_ex.op)
			ALU_OR:   result = id_ex.src_a | id_ex.src_b;
			ALU_AND:  result = id_ex.src_a & id_ex.src_b;
			ALU_XOR:  result = id_ex.src_a ^ id_ex.src_b;
			ALU_NOR:  result = ~(id_ex.src_a | id_ex.src_b);
			ALU_SLL:  result = id_ex.src_b << shamt;
			ALU_SRL:  result = id_ex.src_b >> shamt;
			ALU_SRA:  result = word_t'($signed(id_ex.src_b) >>> shamt);
			ALU_ADDU: result = id_ex.src_a + id_ex.src_b;
			ALU_SUBU: result = id_ex.src_a - id_ex.src_b;
			ALU_SLT:  result = word_t'($signed(id_ex.src_a) < $signed(id_ex.src_b));
			ALU_SLTU: result = word_t'(id_ex.src_a < id_ex.src_b);
			default:  result = id_ex.src_a;  // movn, movz pass rs
		endcase
	end

	// conditional moves test rt
	always_comb begin
		case (id_ex.op)
			ALU_MOVN: cond_ok = id_ex.src_b != '0;
			ALU_MOVZ: cond_ok = id_ex.src_b == '0;
			default:  cond_ok = 1'b1;
		endcase
	end

	assign wr_final = id_ex.valid & id_ex.wr_req & cond_ok;

	assign ex_fwd_en_o   = wr_final & (id_ex.dest != `REG_ZERO);
	assign ex_fwd_addr_o = id_ex.dest;
	assign ex_fwd_data_o = result;

	// whole pipe moves unless a held write is waiting
	assign advance_o = !wb_valid_o | wb_ready_i;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wb_valid_o <= 1'b0;
		end else if (advance_o) begin
			wb_valid_o <= wr_final;
		end
	end

	always_ff @(posedge clk_i) begin
		if (advance_o) begin
			wb_addr_o <= id_ex.dest;
			wb_data_o <= result;
		end
	end

endmodule

// File: src/regfile.sv
`include "mips_consts.svh"

module regfile import mips_pkg::*; (
	input  logic      clk_i,
	input  logic      arst_n_i,
	input  reg_addr_t rd_addr_a_i,
	input  reg_addr_t rd_addr_b_i,
	output word_t     rd_data_a_o,
	output word_t     rd_data_b_o,
	input  logic      wr_en_i,
	input  reg_addr_t wr_addr_i,
	input  word_t     wr_data_i
);

	word_t regs [`REG_COUNT];

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en_i && wr_addr_i != `REG_ZERO) begin
			regs[wr_addr_i] <= wr_data_i;
		end
	end

	// no write bypass here
	assign rd_data_a_o = (rd_addr_a_i == `REG_ZERO) ? '0 : regs[rd_addr_a_i];
	assign rd_data_b_o = (rd_addr_b_i == `REG_ZERO) ? '0 : regs[rd_addr_b_i];

endmodule

// File: decode/id_stage.sv
`include "mips_consts.svh"

module id_stage import mips_pkg::*; (
	input  logic      clk_i,
	input  logic      arst_n_i,
	input  logic      inst_valid_i,
	input  word_t     inst_i,
	input  logic      advance_i,
	output logic      inst_ready_o,
	output reg_addr_t rd_addr_a_o,
	output reg_addr_t rd_addr_b_o,
	input  word_t     rd_data_a_i,
	input  word_t     rd_data_b_i,
	input  logic      ex_fwd_en_i,
	input  reg_addr_t ex_fwd_addr_i,
	input  word_t     ex_fwd_data_i,
	input  logic      wb_fwd_en_i,
	input  reg_addr_t wb_fwd_addr_i,
	input  word_t     wb_fwd_data_i,
	id_ex_if.dec      id_ex
);

	logic        dec_valid_q;
	word_t       inst_q;
	logic [15:0] imm16;
	logic        fn_const_shift;
	alu_op_e     op;
	logic        rd_en_a;
	logic        rd_en_b;
	logic        wr_req;
	reg_addr_t   dest;
	word_t       imm;
	word_t       opnd_a;
	word_t       opnd_b;

	assign inst_ready_o = advance_i;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			dec_valid_q <= 1'b0;
		end else if (advance_i) begin
			dec_valid_q <= inst_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (advance_i && inst_valid_i) begin
			inst_q <= inst_i;
		end
	end

	assign imm16          = inst_q[`IMM_FIELD];
	assign fn_const_shift = inst_q[5:2] == 4'b0000;  // sll, srl, sra
	assign rd_addr_a_o    = inst_q[`RS_FIELD];
	assign rd_addr_b_o    = inst_q[`RT_FIELD];

	always_comb begin
		op      = ALU_NOP;
		rd_en_a = 1'b0;
		rd_en_b = 1'b0;
		wr_req  = 1'b0;
		dest    = inst_q[`RD_FIELD];
		imm     = '0;
		case (inst_q[`OPC_FIELD])
			`OP_SPECIAL: begin
				case (inst_q[`FUNCT_FIELD])
					`FN_SLL, `FN_SLLV: op = ALU_SLL;
					`FN_SRL, `FN_SRLV: op = ALU_SRL;
					`FN_SRA, `FN_SRAV: op = ALU_SRA;
					`FN_MOVZ:          op = ALU_MOVZ;
					`FN_MOVN:          op = ALU_MOVN;
					`FN_ADDU:          op = ALU_ADDU;
					`FN_SUBU:          op = ALU_SUBU;
					`FN_AND:           op = ALU_AND;
					`FN_OR:            op = ALU_OR;
					`FN_XOR:           op = ALU_XOR;
					`FN_NOR:           op = ALU_NOR;
					`FN_SLT:           op = ALU_SLT;
					`FN_SLTU:          op = ALU_SLTU;
					`FN_SYNC:          op = ALU_NOP;
					default:           op = ALU_NOP;
				endcase
				// unused register field must be zero
				if (fn_const_shift ? inst_q[`RS_FIELD] != `REG_ZERO
						: inst_q[`SA_FIELD] != 5'd0) begin
					op = ALU_NOP;
				end
				if (op != ALU_NOP) begin
					rd_en_a = !fn_const_shift;  // sa replaces rs
					rd_en_b = 1'b1;
					wr_req  = 1'b1;
					imm     = word_t'(inst_q[`SA_FIELD]);
				end
			end
			`OP_ORI: begin
				op  = ALU_OR;
				imm = {16'h0, imm16};
			end
			`OP_ANDI: begin
				op  = ALU_AND;
				imm = {16'h0, imm16};
			end
			`OP_XORI: begin
				op  = ALU_XOR;
				imm = {16'h0, imm16};
			end
			`OP_ADDIU: begin
				op  = ALU_ADDU;
				imm = {{16{imm16[15]}}, imm16};
			end
			`OP_SLTI: begin
				op  = ALU_SLT;
				imm = {{16{imm16[15]}}, imm16};
			end
			`OP_SLTIU: begin
				op  = ALU_SLTU;
				imm = {{16{imm16[15]}}, imm16};  // sign extended, compared unsigned
			end
			`OP_LUI: begin
				op  = ALU_OR;  // imm | imm
				imm = {imm16, 16'h0};
			end
			`OP_PREF: op = ALU_NOP;
			default:  op = ALU_NOP;
		endcase
		if (inst_q[`OPC_FIELD] != `OP_SPECIAL && op != ALU_NOP) begin
			rd_en_a = inst_q[`OPC_FIELD] != `OP_LUI;
			wr_req  = 1'b1;
			dest    = inst_q[`RT_FIELD];
		end
	end

	// newest producer wins
	function automatic word_t pick_operand(input logic rd_en, input reg_addr_t addr,
			input word_t rf_data);
		if (!rd_en) begin
			return imm;
		end else if (ex_fwd_en_i && ex_fwd_addr_i == addr) begin
			return ex_fwd_data_i;
		end else if (wb_fwd_en_i && wb_fwd_addr_i == addr) begin
			return wb_fwd_data_i;
		end
		return rf_data;
	endfunction

	always_comb begin
		opnd_a = pick_operand(rd_en_a, inst_q[`RS_FIELD], rd_data_a_i);
		opnd_b = pick_operand(rd_en_b, inst_q[`RT_FIELD], rd_data_b_i);
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			id_ex.valid  <= 1'b0;
			id_ex.wr_req <= 1'b0;
			id_ex.op     <= ALU_NOP;
		end else if (advance_i) begin
			id_ex.valid  <= dec_valid_q;
			id_ex.wr_req <= dec_valid_q & wr_req;
			id_ex.op     <= dec_valid_q ? op : ALU_NOP;
		end
	end

	always_ff @(posedge clk_i) begin
		if (advance_i) begin
			id_ex.src_a <= opnd_a;
			id_ex.src_b <= opnd_b;
			id_ex.dest  <= dest;
		end
	end

endmodule

// File: common/id_ex_if.sv
interface id_ex_if import mips_pkg::*; ();

	logic      valid;
	alu_op_e   op;
	word_t     src_a;   // rs or immediate
	word_t     src_b;   // rt or immediate
	reg_addr_t dest;
	logic      wr_req;  // movn/movz decided later in execute

	modport dec (
		output valid,
		output op,
		output src_a,
		output src_b,
		output dest,
		output wr_req
	);

	modport exe (
		input valid,
		input op,
		input src_a,
		input src_b,
		input dest,
		input wr_req
	);

endinterface

// File: common/mips_pkg.sv
`include "mips_consts.svh"

package mips_pkg;

	typedef logic [`DATA_W-1:0]     word_t;
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

	// what the execute stage does with src_a and src_b
	typedef enum logic [3:0] {
		ALU_NOP,
		ALU_OR,
		ALU_AND,
		ALU_XOR,
		ALU_NOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_ADDU,
		ALU_SUBU,
		ALU_SLT,
		ALU_SLTU,
		ALU_MOVN,
		ALU_MOVZ
	} alu_op_e;

endpackage

// File: common/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

`define DATA_W      32
`define REG_ADDR_W  5
`define REG_COUNT   32

`define REG_ZERO    5'b00000

// instruction fields
`define OPC_FIELD   31:26
`define RS_FIELD    25:21
`define RT_FIELD    20:16
`define RD_FIELD    15:11
`define SA_FIELD    10:6
`define IMM_FIELD   15:0
`define FUNCT_FIELD 5:0

`define OP_SPECIAL  6'b000000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111
`define OP_PREF     6'b110011

`define FN_SLL      6'b000000
`define FN_SRL      6'b000010
`define FN_SRA      6'b000011
`define FN_SLLV     6'b000100
`define FN_SRLV     6'b000110
`define FN_SRAV     6'b000111
`define FN_MOVZ     6'b001010
`define FN_MOVN     6'b001011
`define FN_SYNC     6'b001111
`define FN_ADDU     6'b100001
`define FN_SUBU     6'b100011
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_XOR      6'b100110
`define FN_NOR      6'b100111
`define FN_SLT      6'b101010
`define FN_SLTU     6'b101011

`endif
